//--- source/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  localparam logic [31:0] reset_pc = 32'h8000_0000;

  // major opcodes, inst[6:0]
  localparam logic [6:0] op_lui    = 7'b011_0111;
  localparam logic [6:0] op_auipc  = 7'b001_0111;
  localparam logic [6:0] op_jal    = 7'b110_1111;
  localparam logic [6:0] op_jalr   = 7'b110_0111;
  localparam logic [6:0] op_branch = 7'b110_0011;
  localparam logic [6:0] op_load   = 7'b000_0011;
  localparam logic [6:0] op_store  = 7'b010_0011;
  localparam logic [6:0] op_imm    = 7'b001_0011;
  localparam logic [6:0] op_reg    = 7'b011_0011;
  localparam logic [6:0] op_system = 7'b111_0011;

  // branch compare kinds
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // access size for loads and stores
  localparam logic [2:0] f3_byte   = 3'b000;
  localparam logic [2:0] f3_half   = 3'b001;
  localparam logic [2:0] f3_word   = 3'b010;
  localparam logic [2:0] f3_byte_u = 3'b100;
  localparam logic [2:0] f3_half_u = 3'b101;

  localparam logic [6:0] funct7_sub = 7'b010_0000;

  // one instruction word, six views of the same bits
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } inst_t;

endpackage

`default_nettype wire

//--- source/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
  input  logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
  input  logic [rv_pkg::reg_addr_w-1:0] rd_addr,
  input  logic                          rd_we,
  input  logic [rv_pkg::xlen-1:0]       rd_data,
  output logic [rv_pkg::xlen-1:0]       rs1_data,
  output logic [rv_pkg::xlen-1:0]       rs2_data
);
  import rv_pkg::*;

  logic [xlen-1:0] regs [1:31]; // no storage behind x0

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 1; k < 32; k++) begin
        regs[k] <= '0;
      end
    end else if (rd_we && rd_addr != '0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

//--- source/rv_imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module rv_imm_gen (
  input  rv_pkg::inst_t           inst,
  output logic [rv_pkg::xlen-1:0] imm
);
  import rv_pkg::*;

  always_comb begin
    case (inst.r.opcode)
      op_imm, op_jalr, op_load: begin
        imm = {{20{inst.i.imm[11]}}, inst.i.imm};
      end
      op_store: begin
        imm = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
      end
      op_branch: begin
        // halfword offset, bit 0 always zero
        imm = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
               inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
      end
      op_lui, op_auipc: begin
        imm = {inst.u.imm, 12'h000}; // already in the upper bits
      end
      op_jal: begin
        imm = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
               inst.j.imm_11, inst.j.imm_10_1, 1'b0};
      end
      default: begin
        imm = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- source/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
  input  rv_pkg::inst_t           inst,
  input  logic [rv_pkg::xlen-1:0] pc,
  input  logic [rv_pkg::xlen-1:0] rs1_data,
  input  logic [rv_pkg::xlen-1:0] rs2_data,
  input  logic [rv_pkg::xlen-1:0] imm,
  output logic [rv_pkg::xlen-1:0] sum,
  output logic                    taken
);
  import rv_pkg::*;

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic            sub_en;
  logic            eq;
  logic            lt_s;
  logic            lt_u;

  always_comb begin
    case (inst.r.opcode)
      op_auipc, op_jal, op_branch: op_a = pc; // pc-relative targets
      op_lui:                      op_a = '0;
      default:                     op_a = rs1_data;
    endcase
  end

  assign op_b   = (inst.r.opcode == op_reg) ? rs2_data : imm;
  assign sub_en = (inst.r.opcode == op_reg) && (inst.r.funct7 == funct7_sub);

  // invert and carry in for subtract
  assign sum = op_a + (op_b ^ {xlen{sub_en}}) + {{(xlen-1){1'b0}}, sub_en};

  // comparator kept apart so sum is free for the target
  assign eq   = (rs1_data == rs2_data);
  assign lt_s = ($signed(rs1_data) < $signed(rs2_data));
  assign lt_u = (rs1_data < rs2_data);

  always_comb begin
    case (inst.b.funct3)
      f3_beq:  taken = eq;
      f3_bne:  taken = !eq;
      f3_blt:  taken = lt_s;
      f3_bge:  taken = !lt_s;
      f3_bltu: taken = lt_u;
      f3_bgeu: taken = !lt_u;
      default: taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- source/rv_load_store.sv
`timescale 1ns/1ps
`default_nettype none

module rv_load_store (
  input  rv_pkg::inst_t           inst,
  input  logic [1:0]              addr_low,
  input  logic [rv_pkg::xlen-1:0] rs2_data,
  input  logic [rv_pkg::xlen-1:0] mem_rdata,
  output logic [rv_pkg::xlen-1:0] load_data,
  output logic [rv_pkg::xlen-1:0] store_data,
  output logic [3:0]              store_mask
);
  import rv_pkg::*;

  logic [xlen-1:0] shifted; // addressed lane moved to bit 0

  assign shifted = mem_rdata >> {addr_low, 3'b000};

  always_comb begin
    case (inst.i.funct3)
      f3_byte:   load_data = {{24{shifted[7]}}, shifted[7:0]};
      f3_half:   load_data = {{16{shifted[15]}}, shifted[15:0]};
      f3_byte_u: load_data = {24'h000000, shifted[7:0]};
      f3_half_u: load_data = {16'h0000, shifted[15:0]};
      f3_word:   load_data = mem_rdata;
      default:   load_data = mem_rdata;
    endcase
  end

  // data goes out on every lane, the mask picks the live ones
  always_comb begin
    case (inst.s.funct3)
      f3_byte: begin
        store_data = {4{rs2_data[7:0]}};
        store_mask = 4'b0001 << addr_low;
      end
      f3_half: begin
        store_data = {2{rs2_data[15:0]}};
        store_mask = addr_low[1] ? 4'b1100 : 4'b0011;
      end
      f3_word: begin
        store_data = rs2_data;
        store_mask = 4'b1111;
      end
      default: begin
        store_data = rs2_data;
        store_mask = 4'b0000; // unknown size writes nothing
      end
    endcase
  end

endmodule

`default_nettype wire

//--- source/rv_control.sv
`timescale 1ns/1ps
`default_nettype none

module rv_control (
  input  logic                    clk,
  input  logic                    rst_n,
  output rv_pkg::inst_t           inst,
  output logic [rv_pkg::xlen-1:0] pc,
  input  logic [rv_pkg::xlen-1:0] sum,
  input  logic                    taken,
  input  logic [rv_pkg::xlen-1:0] load_data,
  input  logic [rv_pkg::xlen-1:0] store_data,
  input  logic [3:0]              store_mask,
  output logic                    rd_we,
  output logic [rv_pkg::xlen-1:0] rd_data,
  output logic                    mem_req,
  output logic [rv_pkg::xlen-1:0] mem_addr,
  output logic                    mem_we,
  output logic [rv_pkg::xlen-1:0] mem_wdata,
  output logic [3:0]              mem_wmask,
  input  logic                    mem_ack,
  input  logic [rv_pkg::xlen-1:0] mem_rdata,
  output logic                    halted
);
  import rv_pkg::*;

  enum logic [2:0] {
    st_fetch_req,
    st_fetch_rel,
    st_exec,
    st_data_req,
    st_data_rel,
    st_halt
  } state;

  logic [6:0]      opcode;
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] next_pc;
  logic            bus_done; // ack on an open request
  logic            writes_rd;

  assign opcode   = inst.r.opcode;
  assign pc_plus4 = pc + 32'd4;
  assign bus_done = mem_req & mem_ack;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= st_fetch_req;
      pc      <= reset_pc;
      mem_req <= 1'b0;
    end else begin
      case (state)
        st_fetch_req, st_data_req: begin
          if (!mem_req) begin
            mem_req <= !mem_ack; // open only once the old ack is gone
          end else if (mem_ack) begin
            mem_req <= 1'b0;
            if (state == st_fetch_req) begin
              state <= st_fetch_rel;
            end else begin
              pc    <= pc_plus4; // load/store retires here
              state <= st_data_rel;
            end
          end
        end
        st_fetch_rel: begin
          if (!mem_ack) begin
            state <= st_exec;
          end
        end
        st_exec: begin
          case (opcode)
            op_load, op_store: state <= st_data_req;
            op_system:         state <= st_halt;
            default: begin
              pc    <= next_pc;
              state <= st_fetch_req;
            end
          endcase
        end
        st_data_rel: begin
          if (!mem_ack) begin
            state <= st_fetch_req;
          end
        end
        default: state <= st_halt; // parked for good
      endcase
    end
  end

  // instruction register
  always_ff @(posedge clk) begin
    if (state == st_fetch_req && bus_done) begin
      inst <= mem_rdata;
    end
  end

  always_comb begin
    case (opcode)
      op_jal:    next_pc = sum;
      op_jalr:   next_pc = {sum[xlen-1:1], 1'b0};
      op_branch: next_pc = taken ? sum : pc_plus4;
      default:   next_pc = pc_plus4;
    endcase
  end

  always_comb begin
    case (opcode)
      op_jal, op_jalr: rd_data = pc_plus4; // link
      op_load:         rd_data = load_data;
      default:         rd_data = sum;
    endcase
  end

  assign writes_rd = (opcode == op_lui) || (opcode == op_auipc) ||
                     (opcode == op_jal) || (opcode == op_jalr) ||
                     (opcode == op_imm) || (opcode == op_reg);

  // loads write in the cycle the data ack is taken
  assign rd_we = (state == st_exec && writes_rd) ||
                 (state == st_data_req && bus_done && opcode == op_load);

  assign mem_addr  = (state == st_data_req) ? sum : pc;
  assign mem_we    = (state == st_data_req) && (opcode == op_store);
  assign mem_wdata = store_data;
  assign mem_wmask = mem_we ? store_mask : 4'b0000;

  assign halted = (state == st_halt);

endmodule

`default_nettype wire

//--- source/rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
  input  logic                    clk,
  input  logic                    rst_n,
  output logic                    mem_req,
  output logic [rv_pkg::xlen-1:0] mem_addr,
  output logic                    mem_we,
  output logic [rv_pkg::xlen-1:0] mem_wdata,
  output logic [3:0]              mem_wmask,
  input  logic                    mem_ack,
  input  logic [rv_pkg::xlen-1:0] mem_rdata,
  output logic                    halted
);
  import rv_pkg::*;

  inst_t           inst;
  logic [xlen-1:0] pc;
  logic [xlen-1:0] imm;
  logic [xlen-1:0] sum;
  logic            taken;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic            rd_we;
  logic [xlen-1:0] rd_data;
  logic [xlen-1:0] load_data;
  logic [xlen-1:0] store_data;
  logic [3:0]      store_mask;

  rv_control u_control (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst       (inst),
    .pc         (pc),
    .sum        (sum),
    .taken      (taken),
    .load_data  (load_data),
    .store_data (store_data),
    .store_mask (store_mask),
    .rd_we      (rd_we),
    .rd_data    (rd_data),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr),
    .mem_we     (mem_we),
    .mem_wdata  (mem_wdata),
    .mem_wmask  (mem_wmask),
    .mem_ack    (mem_ack),
    .mem_rdata  (mem_rdata),
    .halted     (halted)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_addr (inst.r.rs1),
    .rs2_addr (inst.r.rs2),
    .rd_addr  (inst.r.rd),
    .rd_we    (rd_we),
    .rd_data  (rd_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_imm_gen u_imm_gen (
    .inst (inst),
    .imm  (imm)
  );

  rv_alu u_alu (
    .inst     (inst),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .imm      (imm),
    .sum      (sum),
    .taken    (taken)
  );

  rv_load_store u_load_store (
    .inst       (inst),
    .addr_low   (sum[1:0]), // byte offset of the data address
    .rs2_data   (rs2_data),
    .mem_rdata  (mem_rdata),
    .load_data  (load_data),
    .store_data (store_data),
    .store_mask (store_mask)
  );

endmodule

`default_nettype wire

//--- verif/rv_core_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_checker (
  input logic        clk,
  input logic        rst_n,
  input logic        mem_req,
  input logic [31:0] mem_addr,
  input logic        mem_we,
  input logic [31:0] mem_wdata,
  input logic [3:0]  mem_wmask,
  input logic        mem_ack,
  input logic        halted
);

  // bus idle and not halted while reset is held
  reset_idle: assert property (@(posedge clk) !rst_n |-> !mem_req && !mem_we && !halted)
    else $error("bus request or halt active during reset");

  // a new request waits for the old ack to clear
  req_after_ack_low: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(mem_req) |-> !mem_ack)
    else $error("request raised while ack still high");

  req_fields_stable: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req && !mem_ack |=> $stable(mem_addr) && $stable(mem_we) &&
                            $stable(mem_wdata) && $stable(mem_wmask))
    else $error("request fields changed before ack");

  req_drop_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(mem_req) |-> $past(mem_ack))
    else $error("request dropped without ack");

  // once parked the core stays parked and silent
  halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    halted |=> halted && !mem_req)
    else $error("core left halt or requested the bus");

endmodule

bind rv_core_top rv_core_checker u_checker (.*);

`default_nettype wire

//--- verif/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;
  import rv_pkg::*;

  logic        clk       = 1'b0;
  logic        rst_n     = 1'b0;
  logic        mem_ack   = 1'b0;
  logic [31:0] mem_rdata = 32'h0;
  logic        mem_req;
  logic [31:0] mem_addr;
  logic        mem_we;
  logic [31:0] mem_wdata;
  logic [3:0]  mem_wmask;
  logic        halted;

  logic [31:0] image [0:511]; // program and data as loaded at reset
  logic [31:0] mem [0:511];
  logic [8:0]  pc_i;
  logic [8:0]  slot;          // next result word
  logic [1:0]  wait_cnt = 2'd0;
  integer      seed = 32'he310_8914;
  int          errors = 0;
  int          checks = 0;
  int          cycles;
  logic [31:0] link;
  logic [8:0]  exp_idx [$];
  logic [31:0] exp_val [$];
  string       exp_name [$];

  always #5 clk = ~clk;

  rv_core_top uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_req   (mem_req),
    .mem_addr  (mem_addr),
    .mem_we    (mem_we),
    .mem_wdata (mem_wdata),
    .mem_wmask (mem_wmask),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata),
    .halted    (halted)
  );

  function automatic logic [8:0] word_index(input logic [31:0] addr);
    logic [31:0] off;
    off = addr - reset_pc;
    return off[10:2];
  endfunction

  function automatic logic [31:0] addr_of(input logic [8:0] idx);
    return reset_pc + {21'd0, idx, 2'b00};
  endfunction

  // preload pattern, unique per word
  function automatic logic [31:0] fill_word(input logic [8:0] idx);
    return {16'hf111, 7'd0, idx};
  endfunction

  // handshaking memory with a random ack delay of 0 to 3 cycles
  always @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < 512; k++) begin
        mem[k] <= image[k];
      end
      mem_ack <= 1'b0;
    end else if (mem_req && !mem_ack) begin
      if (wait_cnt == 2'd0) begin
        for (int b = 0; b < 4; b++) begin
          if (mem_we && mem_wmask[b]) begin
            mem[word_index(mem_addr)][8*b +: 8] <= mem_wdata[8*b +: 8];
          end
        end
        mem_rdata <= mem[word_index(mem_addr)];
        mem_ack   <= 1'b1;
      end else begin
        wait_cnt <= wait_cnt - 2'd1;
      end
    end else if (!mem_req && mem_ack) begin
      mem_ack  <= 1'b0;
      wait_cnt <= 2'($random(seed));
    end
  end

  function automatic logic [31:0] encode_r(input logic [6:0] f7, input int rs2,
                                           input int rs1, input int rd);
    return {f7, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], op_reg};
  endfunction

  function automatic logic [31:0] encode_i(input logic [6:0] op, input int rd,
                                           input logic [2:0] f3, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
  endfunction

  function automatic logic [31:0] encode_s(input logic [2:0] f3, input int rs1,
                                           input int rs2, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] encode_b(input logic [2:0] f3, input int rs1,
                                           input int rs2, input int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic logic [31:0] encode_u(input logic [6:0] op, input int rd, input int imm);
    return {imm[19:0], rd[4:0], op};
  endfunction

  function automatic logic [31:0] encode_j(input int rd, input int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], op_jal};
  endfunction

  task automatic emit(input logic [31:0] w);
    image[pc_i] = w;
    pc_i = pc_i + 9'd1;
  endtask

  task automatic expect_word(input string name, input logic [31:0] val);
    exp_idx.push_back(9'd256 + slot);
    exp_val.push_back(val);
    exp_name.push_back(name);
    slot = slot + 9'd1;
  endtask

  // result words sit at x1 = reset_pc + 0x400
  task automatic store_result(input int rs, input string name, input logic [31:0] val);
    emit(encode_s(f3_word, 1, rs, int'(slot) * 4));
    expect_word(name, val);
  endtask

  task automatic branch_pair(input logic [2:0] f3, input string name,
                             input int ta, input int tb, input int na, input int nb);
    emit(encode_b(f3, ta, tb, 8));
    store_result(8, {name, "_skip"}, fill_word(9'd256 + slot));  // must be jumped over
    store_result(9, {name, "_target"}, 32'h1);
    emit(encode_b(f3, na, nb, 8));
    store_result(9, {name, "_fall"}, 32'h1);
  endtask

  task automatic load_result(input logic [2:0] f3, input int off, input string name,
                             input logic [31:0] val);
    emit(encode_i(op_load, 14, f3, 13, off));
    store_result(14, name, val);
  endtask

  task automatic part_store(input logic [2:0] f3, input int lane, input string name,
                            input logic [31:0] val);
    image[9'd256 + slot] = 32'h0; // merge target starts empty
    emit(encode_s(f3, 1, 15, int'(slot) * 4 + lane));
    expect_word(name, val);
  endtask

  initial begin
    for (int k = 0; k < 512; k++) begin
      image[k] = fill_word(9'(k));
    end
    pc_i = 9'd0;
    slot = 9'd0;
    emit(encode_u(op_lui, 1, 32'h80000));
    emit(encode_i(op_imm, 1, 3'b000, 1, 32'h400));
    emit(encode_i(op_imm, 2, 3'b000, 0, -5));
    emit(encode_i(op_imm, 3, 3'b000, 0, 100));
    emit(encode_r(7'd0, 3, 2, 4));
    emit(encode_r(funct7_sub, 3, 2, 5));
    emit(encode_u(op_lui, 6, 32'h12345));
    link = addr_of(pc_i) + 32'h1000; // auipc result
    emit(encode_u(op_auipc, 7, 1));
    store_result(2, "addi_neg", 32'hffff_fffb);
    store_result(4, "add", 32'h0000_005f);
    store_result(5, "sub", 32'hffff_ff97);
    store_result(6, "lui", 32'h1234_5000);
    store_result(7, "auipc", link);
    emit(encode_i(op_imm, 8, 3'b000, 0, 32'h5ad)); // skip marker
    emit(encode_i(op_imm, 9, 3'b000, 0, 1));
    // x2 = -5, x3 = 100
    branch_pair(f3_beq, "beq", 3, 3, 2, 3);
    branch_pair(f3_bne, "bne", 2, 3, 3, 3);
    branch_pair(f3_blt, "blt", 2, 3, 3, 2);
    branch_pair(f3_bge, "bge", 3, 2, 2, 3);
    branch_pair(f3_bltu, "bltu", 3, 2, 2, 3);
    branch_pair(f3_bgeu, "bgeu", 2, 3, 3, 2);
    link = addr_of(pc_i) + 32'd4;
    emit(encode_j(10, 8));
    store_result(8, "jal_skip", fill_word(9'd256 + slot));
    store_result(10, "jal_link", link);
    emit(encode_u(op_auipc, 11, 0));
    link = addr_of(pc_i) + 32'd4;
    emit(encode_i(op_jalr, 12, 3'b000, 11, 13)); // odd target loses bit 0
    store_result(8, "jalr_skip", fill_word(9'd256 + slot));
    store_result(12, "jalr_link", link);
    emit(encode_i(op_imm, 13, 3'b000, 1, -512));
    load_result(f3_byte, 0, "lb_0", 32'h0000_0001);
    load_result(f3_byte, 1, "lb_1", 32'hffff_ffc3);
    load_result(f3_byte, 3, "lb_3", 32'hffff_ff8a);
    load_result(f3_byte_u, 1, "lbu_1", 32'h0000_00c3);
    load_result(f3_byte_u, 3, "lbu_3", 32'h0000_008a);
    load_result(f3_half, 0, "lh_0", 32'hffff_c301);
    load_result(f3_half, 2, "lh_2", 32'hffff_8a7f);
    load_result(f3_half_u, 0, "lhu_0", 32'h0000_c301);
    load_result(f3_half_u, 2, "lhu_2", 32'h0000_8a7f);
    load_result(f3_word, 0, "lw_0", 32'h8a7f_c301);
    emit(encode_u(op_lui, 15, 32'ha1b2c));
    emit(encode_i(op_imm, 15, 3'b000, 15, 32'h3d4));
    part_store(f3_byte, 0, "sb_0", 32'h0000_00d4);
    part_store(f3_byte, 1, "sb_1", 32'h0000_d400);
    part_store(f3_byte, 2, "sb_2", 32'h00d4_0000);
    part_store(f3_byte, 3, "sb_3", 32'hd400_0000);
    part_store(f3_half, 0, "sh_0", 32'h0000_c3d4);
    part_store(f3_half, 2, "sh_2", 32'hc3d4_0000);
    emit(encode_i(op_system, 0, 3'b000, 0, 1)); // ebreak
    image[128] = 32'h8a7f_c301;

    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    cycles = 0;
    while (!halted && cycles < 20000) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) begin
      $display("Timeout: core did not halt within %0d cycles", cycles);
      errors++;
    end else begin
      for (int n = 0; n < 20; n++) begin
        @(negedge clk);
        checks++;
        assert (halted && !mem_req) else begin
          $display("Core left halt or issued a bus request after ebreak");
          errors++;
        end
      end
      foreach (exp_idx[n]) begin
        checks++;
        assert (mem[exp_idx[n]] == exp_val[n]) else begin
          $display("Error: %s expected %h actual %h", exp_name[n], exp_val[n],
                   mem[exp_idx[n]]);
          errors++;
        end
      end
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
source/rv_pkg.sv
source/rv_regfile.sv
source/rv_imm_gen.sv
source/rv_alu.sv
source/rv_load_store.sv
source/rv_control.sv
source/rv_core_top.sv
verif/rv_core_checker.sv
verif/tb_rv_core.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_rv_core -f sim.f -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "All checks passed" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
